/* decoder_riscv.f */
+incdir+verification
verilog/riscv_isa_pkg.sv
verilog/decoder_ctrl_pkg.sv
verilog/opcode_classifier.sv
verilog/alu_op_decoder.sv
verilog/control_word_builder.sv
verilog/decoder_riscv.sv
verification/tb_decoder_riscv.sv

/* run_sim.sh */
#!/bin/sh
# Builds the decoder testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f decoder_riscv.f \
    --top-module tb_decoder_riscv -o sim_decoder > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_decoder > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Some tests failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

/* verification/tb_decoder_vectors.svh */
/*
 * Decoder test vectors.
 * One row per instruction word with the control word the ID stage
 * must produce for it, illegal words listed by their encoding only.
 */

// Columns: word, a_sel, b_sel, alu_op, {mem_req, mem_we, mem_size}, gpr_we,
// wb_sel, {branch, jal, jalr, illegal}.
task automatic load_vector_table();
    // R-type arithmetic.
    add_vector(encode(7'h00, 3'd0, 7'h33), A_RS1, B_RS2, ALU_ADD, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h20, 3'd0, 7'h33), A_RS1, B_RS2, ALU_SUB, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h00, 3'd1, 7'h33), A_RS1, B_RS2, ALU_SLL, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h00, 3'd2, 7'h33), A_RS1, B_RS2, ALU_SLTS, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h00, 3'd3, 7'h33), A_RS1, B_RS2, ALU_SLTU, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h00, 3'd4, 7'h33), A_RS1, B_RS2, ALU_XOR, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h00, 3'd5, 7'h33), A_RS1, B_RS2, ALU_SRL, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h20, 3'd5, 7'h33), A_RS1, B_RS2, ALU_SRA, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h00, 3'd6, 7'h33), A_RS1, B_RS2, ALU_OR, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h00, 3'd7, 7'h33), A_RS1, B_RS2, ALU_AND, 5'h03, 1'b1, WB_ALU, 4'h0);
    // I-type arithmetic, funct7 holds immediate bits except on shifts.
    add_vector(encode(7'h20, 3'd0, 7'h13), A_RS1, B_IMM_I, ALU_ADD, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h00, 3'd1, 7'h13), A_RS1, B_IMM_I, ALU_SLL, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h7f, 3'd2, 7'h13), A_RS1, B_IMM_I, ALU_SLTS, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h00, 3'd3, 7'h13), A_RS1, B_IMM_I, ALU_SLTU, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h55, 3'd4, 7'h13), A_RS1, B_IMM_I, ALU_XOR, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h00, 3'd5, 7'h13), A_RS1, B_IMM_I, ALU_SRL, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h20, 3'd5, 7'h13), A_RS1, B_IMM_I, ALU_SRA, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h7f, 3'd7, 7'h13), A_RS1, B_IMM_I, ALU_AND, 5'h03, 1'b1, WB_ALU, 4'h0);
    // Loads and stores.
    add_vector(encode(7'h00, 3'd0, 7'h03), A_RS1, B_IMM_I, ALU_ADD, 5'h10, 1'b1, WB_LSU, 4'h0);
    add_vector(encode(7'h00, 3'd1, 7'h03), A_RS1, B_IMM_I, ALU_ADD, 5'h11, 1'b1, WB_LSU, 4'h0);
    add_vector(encode(7'h00, 3'd2, 7'h03), A_RS1, B_IMM_I, ALU_ADD, 5'h12, 1'b1, WB_LSU, 4'h0);
    add_vector(encode(7'h00, 3'd4, 7'h03), A_RS1, B_IMM_I, ALU_ADD, 5'h14, 1'b1, WB_LSU, 4'h0);
    add_vector(encode(7'h00, 3'd5, 7'h03), A_RS1, B_IMM_I, ALU_ADD, 5'h15, 1'b1, WB_LSU, 4'h0);
    add_vector(encode(7'h00, 3'd0, 7'h23), A_RS1, B_IMM_S, ALU_ADD, 5'h18, 1'b0, WB_ALU, 4'h0);
    add_vector(encode(7'h00, 3'd1, 7'h23), A_RS1, B_IMM_S, ALU_ADD, 5'h19, 1'b0, WB_ALU, 4'h0);
    add_vector(encode(7'h00, 3'd2, 7'h23), A_RS1, B_IMM_S, ALU_ADD, 5'h1a, 1'b0, WB_ALU, 4'h0);
    // Branches and jumps.
    add_vector(encode(7'h00, 3'd0, 7'h63), A_RS1, B_RS2, ALU_EQ, 5'h03, 1'b0, WB_ALU, 4'h8);
    add_vector(encode(7'h00, 3'd1, 7'h63), A_RS1, B_RS2, ALU_NE, 5'h03, 1'b0, WB_ALU, 4'h8);
    add_vector(encode(7'h00, 3'd4, 7'h63), A_RS1, B_RS2, ALU_LTS, 5'h03, 1'b0, WB_ALU, 4'h8);
    add_vector(encode(7'h00, 3'd5, 7'h63), A_RS1, B_RS2, ALU_GES, 5'h03, 1'b0, WB_ALU, 4'h8);
    add_vector(encode(7'h00, 3'd6, 7'h63), A_RS1, B_RS2, ALU_LTU, 5'h03, 1'b0, WB_ALU, 4'h8);
    add_vector(encode(7'h00, 3'd7, 7'h63), A_RS1, B_RS2, ALU_GEU, 5'h03, 1'b0, WB_ALU, 4'h8);
    add_vector(encode(7'h12, 3'd5, 7'h6f), A_PC, B_FOUR, ALU_ADD, 5'h03, 1'b1, WB_ALU, 4'h4);
    add_vector(encode(7'h00, 3'd0, 7'h67), A_PC, B_FOUR, ALU_ADD, 5'h03, 1'b1, WB_ALU, 4'h2);
    // Upper immediates and FENCE.
    add_vector(encode(7'h7a, 3'd6, 7'h37), A_ZERO, B_IMM_U, ALU_ADD, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h01, 3'd2, 7'h17), A_PC, B_IMM_U, ALU_ADD, 5'h03, 1'b1, WB_ALU, 4'h0);
    add_vector(encode(7'h07, 3'd0, 7'h0f), A_RS1, B_RS2, ALU_ADD, 5'h03, 1'b0, WB_ALU, 4'h0);
    // SYSTEM: ECALL, EBREAK, MRET, CSRRW.
    add_illegal(32'h0000_0073);
    add_illegal(32'h0010_0073);
    add_illegal(32'h3020_0073);
    add_illegal(encode(7'h00, 3'd1, 7'h73));
    // Size bits other than 2'b11.
    add_illegal(encode(7'h00, 3'd0, 7'h32));
    add_illegal(encode(7'h00, 3'd0, 7'h11));
    add_illegal(encode(7'h00, 3'd2, 7'h00));
    // Bad funct7, then bad funct3, then unused opcodes.
    add_illegal(encode(7'h01, 3'd0, 7'h33));
    add_illegal(encode(7'h20, 3'd4, 7'h33));
    add_illegal(encode(7'h20, 3'd1, 7'h13));
    add_illegal(encode(7'h01, 3'd5, 7'h13));
    add_illegal(encode(7'h00, 3'd3, 7'h03));
    add_illegal(encode(7'h00, 3'd6, 7'h03));
    add_illegal(encode(7'h00, 3'd3, 7'h23));
    add_illegal(encode(7'h00, 3'd2, 7'h63));
    add_illegal(encode(7'h00, 3'd3, 7'h63));
    add_illegal(encode(7'h00, 3'd1, 7'h67));
    add_illegal(encode(7'h00, 3'd1, 7'h0f));
    add_illegal(encode(7'h00, 3'd2, 7'h2f));
    add_illegal(32'hffff_ffff);
endtask

/* verification/tb_decoder_riscv.sv */
/*
 * Testbench for the RV32I ID-stage decoder.
 * Applies the vector table back to back and with idle cycles, plus
 * random words that match no kept pattern, and checks every field.
 */
`timescale 1ns/1ps

module tb_decoder_riscv;

    import riscv_isa_pkg::*;
    import decoder_ctrl_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int MAX_CYCLES   = 2000;
    localparam int RANDOM_WORDS = 16;
    localparam int SEED         = 76074;

    logic         clk;
    logic         arst_n;
    logic         instr_valid;
    instr_t       fetched_instr;
    decode_ctrl_t ctrl;
    logic         ctrl_valid;

    instr_t       vec_instr[$];
    decode_ctrl_t vec_ctrl[$];
    int           checks;
    int           errors;

    decoder_riscv UUT (
        .clk_i           (clk),
        .arst_n_i        (arst_n),
        .instr_valid_i   (instr_valid),
        .fetched_instr_i (fetched_instr),
        .ctrl_o          (ctrl),
        .ctrl_valid_o    (ctrl_valid)
    );

    always #2 clk = ~clk;

    // Fixed registers rd = x3, rs1 = x1, rs2 = x2.
    function automatic instr_t encode(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [6:0] opc);
        return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
    endfunction

    task automatic add_vector(input instr_t word, input a_sel_t a_sel, input b_sel_t b_sel,
                              input alu_op_t alu_op, input logic [4:0] mem,
                              input logic gpr_we, input wb_sel_t wb_sel,
                              input logic [3:0] flow);
        decode_ctrl_t c;
        c.a_sel  = a_sel;
        c.b_sel  = b_sel;
        c.alu_op = alu_op;
        {c.mem_req, c.mem_we, c.mem_size} = mem;
        c.gpr_we = gpr_we;
        c.wb_sel = wb_sel;
        {c.branch, c.jal, c.jalr, c.illegal} = flow;
        vec_instr.push_back(word);
        vec_ctrl.push_back(c);
    endtask

    task automatic add_illegal(input instr_t word);
        add_vector(word, A_RS1, B_RS2, ALU_ADD, 5'h03, 1'b0, WB_ALU, 4'h1);
    endtask

    // Kept RV32I patterns, SYSTEM excluded.
    function automatic logic is_kept(input instr_t w);
        logic [2:0] f3;
        logic [6:0] f7;
        logic       kept;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            7'h33: kept = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            7'h13: kept = (f3 == 3'd1) ? (f7 == 7'h00) :
                          (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
            7'h03: kept = (f3 != 3'd3) && (f3 < 3'd6);
            7'h23: kept = (f3 <= 3'd2);
            7'h63: kept = (f3 != 3'd2) && (f3 != 3'd3);
            7'h6f, 7'h37, 7'h17: kept = 1'b1;
            7'h67, 7'h0f: kept = (f3 == 3'd0);
            default: kept = 1'b0;
        endcase
        return kept;
    endfunction

    task automatic add_random_illegal(input int count);
        instr_t w;
        int     added;
        int     tries;
        added = 0;
        tries = 0;
        while (added < count && tries < 100 * count) begin
            w = $urandom;
            // Every other try gets valid size bits so the opcode rules are reached.
            if (tries % 2 == 0) begin
                w[1:0] = 2'b11;
            end
            if (!is_kept(w)) begin
                add_illegal(w);
                added++;
            end
            tries++;
        end
    endtask

    `include "tb_decoder_vectors.svh"

    task automatic check_value(input string name, input instr_t word,
                               input logic [31:0] actual, input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR: %s = %h, expected %h (instr %h, time %0t)",
                     name, actual, expected, word, $time);
        end
    endtask

    task automatic compare_ctrl(input instr_t word, input decode_ctrl_t exp,
                                input logic exp_valid);
        check_value("ctrl_valid_o", word, 32'(ctrl_valid), 32'(exp_valid));
        check_value("ctrl_o.a_sel", word, 32'(ctrl.a_sel), 32'(exp.a_sel));
        check_value("ctrl_o.b_sel", word, 32'(ctrl.b_sel), 32'(exp.b_sel));
        check_value("ctrl_o.alu_op", word, 32'(ctrl.alu_op), 32'(exp.alu_op));
        check_value("ctrl_o.mem_req", word, 32'(ctrl.mem_req), 32'(exp.mem_req));
        check_value("ctrl_o.mem_we", word, 32'(ctrl.mem_we), 32'(exp.mem_we));
        check_value("ctrl_o.mem_size", word, 32'(ctrl.mem_size), 32'(exp.mem_size));
        check_value("ctrl_o.gpr_we", word, 32'(ctrl.gpr_we), 32'(exp.gpr_we));
        check_value("ctrl_o.wb_sel", word, 32'(ctrl.wb_sel), 32'(exp.wb_sel));
        check_value("ctrl_o.branch", word, 32'(ctrl.branch), 32'(exp.branch));
        check_value("ctrl_o.jal", word, 32'(ctrl.jal), 32'(exp.jal));
        check_value("ctrl_o.jalr", word, 32'(ctrl.jalr), 32'(exp.jalr));
        check_value("ctrl_o.illegal", word, 32'(ctrl.illegal), 32'(exp.illegal));
    endtask

    // One word per cycle; idle_every > 0 inserts an idle cycle after every n-th word.
    task automatic run_pass(input int idle_every);
        for (int i = 0; i < vec_instr.size(); i++) begin
            fetched_instr = vec_instr[i];
            instr_valid   = 1'b1;
            @(negedge clk);
            compare_ctrl(vec_instr[i], vec_ctrl[i], 1'b1);
            if (idle_every > 0 && i % idle_every == idle_every - 1) begin
                // Junk on the bus while idle must not reach ctrl_o.
                fetched_instr = $urandom;
                instr_valid   = 1'b0;
                @(negedge clk);
                compare_ctrl(vec_instr[i], vec_ctrl[i], 1'b0);
            end
        end
        instr_valid = 1'b0;
    endtask

    initial begin
        clk           = 1'b0;
        arst_n        = 1'b0;
        instr_valid   = 1'b0;
        fetched_instr = '0;
        checks        = 0;
        errors        = 0;
        void'($urandom(SEED));
        load_vector_table();
        add_random_illegal(RANDOM_WORDS);

        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_value("ctrl_valid_o", '0, 32'(ctrl_valid), 32'h0);
        check_value("ctrl_o", '0, 32'(ctrl), 32'h0);

        run_pass(0);
        run_pass(4);
        @(negedge clk);
        check_value("ctrl_valid_o", '0, 32'(ctrl_valid), 32'h0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        for (int cycle = 0; cycle < MAX_CYCLES; cycle++) begin
            @(posedge clk);
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* verilog/alu_op_decoder.sv */
/*
 * ALU operation decoder.
 * Maps funct3, and funct7 where it selects SUB or SRA, to the ALU code
 * for arithmetic and branch classes. Other classes add.
 */
`timescale 1ns/1ps

module alu_op_decoder (
    input  decoder_ctrl_pkg::instr_class_e instr_class_i,
    input  riscv_isa_pkg::funct3_t         funct3_i,
    input  riscv_isa_pkg::funct7_t         funct7_i,
    output decoder_ctrl_pkg::alu_op_t      alu_op_o
);

    import riscv_isa_pkg::*;
    import decoder_ctrl_pkg::*;

    logic alt;

    // ADDI has immediate bits in funct7, so only OP and the shifts look at it.
    assign alt = (funct7_i == FUNCT7_ALT) &&
                 (instr_class_i == CLS_OP || funct3_i == F3_SRL_SRA);

    always_comb begin
        alu_op_o = ALU_ADD;
        case (instr_class_i)
            CLS_OP, CLS_OP_IMM: begin
                case (funct3_i)
                    F3_ADD_SUB: alu_op_o = alt ? ALU_SUB : ALU_ADD;
                    F3_SLL:     alu_op_o = ALU_SLL;
                    F3_SLT:     alu_op_o = ALU_SLTS;
                    F3_SLTU:    alu_op_o = ALU_SLTU;
                    F3_XOR:     alu_op_o = ALU_XOR;
                    F3_SRL_SRA: alu_op_o = alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      alu_op_o = ALU_OR;
                    F3_AND:     alu_op_o = ALU_AND;
                    default:    alu_op_o = ALU_ADD;
                endcase
            end
            CLS_BRANCH: begin
                case (funct3_i)
                    F3_BEQ:  alu_op_o = ALU_EQ;
                    F3_BNE:  alu_op_o = ALU_NE;
                    F3_BLT:  alu_op_o = ALU_LTS;
                    F3_BGE:  alu_op_o = ALU_GES;
                    F3_BLTU: alu_op_o = ALU_LTU;
                    F3_BGEU: alu_op_o = ALU_GEU;
                    default: alu_op_o = ALU_ADD;
                endcase
            end
            default: alu_op_o = ALU_ADD;
        endcase
    end

    // The classifier never lets a branch with funct3 2 or 3 through.
    always_comb begin
        if (instr_class_i == CLS_BRANCH) begin
            a_branch_cmp: assert (alu_op_o inside {ALU_EQ, ALU_NE, ALU_LTS,
                                                   ALU_GES, ALU_LTU, ALU_GEU})
                else $error("alu_op_decoder: branch without compare code");
        end
    end

endmodule

/* verilog/control_word_builder.sv */
/*
 * Control word builder and decode-stage register.
 * Fills operand selects, memory fields and write enables per class,
 * then registers the word together with its valid bit.
 */
`timescale 1ns/1ps

module control_word_builder (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           instr_valid_i,
    input  decoder_ctrl_pkg::instr_class_e instr_class_i,
    input  decoder_ctrl_pkg::alu_op_t      alu_op_i,
    input  riscv_isa_pkg::funct3_t         funct3_i,
    output decoder_ctrl_pkg::decode_ctrl_t ctrl_o,
    output logic                           ctrl_valid_o
);

    import decoder_ctrl_pkg::*;

    decode_ctrl_t ctrl_next;

    always_comb begin
        ctrl_next          = '0;
        ctrl_next.a_sel    = A_RS1;
        ctrl_next.b_sel    = B_RS2;
        ctrl_next.alu_op   = alu_op_i;
        ctrl_next.mem_size = MEM_SIZE_IDLE;
        ctrl_next.wb_sel   = WB_ALU;
        case (instr_class_i)
            CLS_OP: begin
                ctrl_next.gpr_we = 1'b1;
            end
            CLS_OP_IMM: begin
                ctrl_next.b_sel  = B_IMM_I;
                ctrl_next.gpr_we = 1'b1;
            end
            CLS_LOAD: begin
                ctrl_next.b_sel    = B_IMM_I;
                ctrl_next.mem_req  = 1'b1;
                ctrl_next.mem_size = funct3_i;
                ctrl_next.gpr_we   = 1'b1;
                ctrl_next.wb_sel   = WB_LSU;
            end
            CLS_STORE: begin
                ctrl_next.b_sel    = B_IMM_S;
                ctrl_next.mem_req  = 1'b1;
                ctrl_next.mem_we   = 1'b1;
                ctrl_next.mem_size = funct3_i;
            end
            CLS_BRANCH: begin
                ctrl_next.branch = 1'b1;
            end
            CLS_JAL: begin
                ctrl_next.a_sel  = A_PC;
                ctrl_next.b_sel  = B_FOUR;
                ctrl_next.gpr_we = 1'b1;
                ctrl_next.jal    = 1'b1;
            end
            CLS_JALR: begin
                ctrl_next.a_sel  = A_PC;
                ctrl_next.b_sel  = B_FOUR;
                ctrl_next.gpr_we = 1'b1;
                ctrl_next.jalr   = 1'b1;
            end
            CLS_LUI: begin
                ctrl_next.a_sel  = A_ZERO;
                ctrl_next.b_sel  = B_IMM_U;
                ctrl_next.gpr_we = 1'b1;
            end
            CLS_AUIPC: begin
                ctrl_next.a_sel  = A_PC;
                ctrl_next.b_sel  = B_IMM_U;
                ctrl_next.gpr_we = 1'b1;
            end
            CLS_FENCE: begin
                // Executes as a no-op on this in-order core.
                ctrl_next.gpr_we = 1'b0;
            end
            default: begin
                ctrl_next.alu_op  = ALU_ADD;
                ctrl_next.illegal = 1'b1;
            end
        endcase
    end

    // Output word holds its last value across idle cycles.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_o       <= '0;
            ctrl_valid_o <= 1'b0;
        end else begin
            ctrl_valid_o <= instr_valid_i;
            if (instr_valid_i) begin
                ctrl_o <= ctrl_next;
            end
        end
    end

    a_we_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ctrl_valid_o && ctrl_o.mem_we |-> ctrl_o.mem_req)
        else $error("control_word_builder: mem_we without mem_req");

    a_illegal_no_wb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ctrl_valid_o && ctrl_o.illegal |-> !ctrl_o.gpr_we)
        else $error("control_word_builder: gpr_we on illegal instruction");

endmodule

/* verilog/decoder_ctrl_pkg.sv */
/*
 * Decoder control-word encodings.
 * Operand and write-back selects, ALU operation codes, the instruction
 * class enum and the packed control word handed to the execute stage.
 */
package decoder_ctrl_pkg;

    typedef logic [4:0] alu_op_t;
    typedef logic [1:0] a_sel_t;
    typedef logic [2:0] b_sel_t;
    typedef logic [1:0] wb_sel_t;
    typedef logic [2:0] mem_size_t;

    localparam alu_op_t ALU_ADD  = 5'd0;
    localparam alu_op_t ALU_SLL  = 5'd1;
    localparam alu_op_t ALU_SLTS = 5'd2;
    localparam alu_op_t ALU_SLTU = 5'd3;
    localparam alu_op_t ALU_XOR  = 5'd4;
    localparam alu_op_t ALU_SRL  = 5'd5;
    localparam alu_op_t ALU_OR   = 5'd6;
    localparam alu_op_t ALU_AND  = 5'd7;
    localparam alu_op_t ALU_SUB  = 5'd8;
    localparam alu_op_t ALU_SRA  = 5'd13;
    // Compare codes, all with bits 4 and 3 set.
    localparam alu_op_t ALU_EQ   = 5'd24;
    localparam alu_op_t ALU_NE   = 5'd25;
    localparam alu_op_t ALU_LTS  = 5'd28;
    localparam alu_op_t ALU_GES  = 5'd29;
    localparam alu_op_t ALU_LTU  = 5'd30;
    localparam alu_op_t ALU_GEU  = 5'd31;

    localparam a_sel_t A_RS1  = 2'd0;
    localparam a_sel_t A_PC   = 2'd1;
    localparam a_sel_t A_ZERO = 2'd2;

    localparam b_sel_t B_RS2   = 3'd0;
    localparam b_sel_t B_IMM_I = 3'd1;
    localparam b_sel_t B_IMM_U = 3'd2;
    localparam b_sel_t B_IMM_S = 3'd3;
    localparam b_sel_t B_FOUR  = 3'd4;

    localparam wb_sel_t WB_ALU = 2'd0;
    localparam wb_sel_t WB_LSU = 2'd1;

    localparam mem_size_t MEM_SIZE_IDLE = 3'd3;

    typedef enum logic [3:0] {
        CLS_ILLEGAL,
        CLS_OP,
        CLS_OP_IMM,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_LUI,
        CLS_AUIPC,
        CLS_FENCE
    } instr_class_e;

    typedef struct packed {
        a_sel_t    a_sel;
        b_sel_t    b_sel;
        alu_op_t   alu_op;
        logic      mem_req;
        logic      mem_we;
        mem_size_t mem_size;
        logic      gpr_we;
        wb_sel_t   wb_sel;
        logic      branch;
        logic      jal;
        logic      jalr;
        logic      illegal;
    } decode_ctrl_t;

endpackage

/* verilog/decoder_riscv.sv */
/*
 * RV32I main decoder, ID stage.
 * Classifies the fetched word, derives the ALU operation and registers
 * the resulting control word one cycle after the instruction is sampled.
 */
`timescale 1ns/1ps

module decoder_riscv (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           instr_valid_i,
    input  riscv_isa_pkg::instr_t          fetched_instr_i,
    output decoder_ctrl_pkg::decode_ctrl_t ctrl_o,
    output logic                           ctrl_valid_o
);

    import riscv_isa_pkg::*;
    import decoder_ctrl_pkg::*;

    funct3_t      funct3;
    funct7_t      funct7;
    instr_class_e instr_class;
    alu_op_t      alu_op;

    assign funct3 = fetched_instr_i[14:12];
    assign funct7 = fetched_instr_i[31:25];

    opcode_classifier u_classifier (
        .fetched_instr_i (fetched_instr_i),
        .instr_class_o   (instr_class)
    );

    alu_op_decoder u_alu_op (
        .instr_class_i (instr_class),
        .funct3_i      (funct3),
        .funct7_i      (funct7),
        .alu_op_o      (alu_op)
    );

    control_word_builder u_builder (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_class_i (instr_class),
        .alu_op_i      (alu_op),
        .funct3_i      (funct3),
        .ctrl_o        (ctrl_o),
        .ctrl_valid_o  (ctrl_valid_o)
    );

endmodule

/* verilog/opcode_classifier.sv */
/*
 * RV32I opcode classifier.
 * Checks size bits, opcode, funct3 and funct7 of a fetched word and
 * names the instruction class. Anything outside the kept base classes,
 * SYSTEM words included, comes out as CLS_ILLEGAL.
 */
`timescale 1ns/1ps

module opcode_classifier (
    input  riscv_isa_pkg::instr_t          fetched_instr_i,
    output decoder_ctrl_pkg::instr_class_e instr_class_o
);

    import riscv_isa_pkg::*;
    import decoder_ctrl_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    size_ok;
    logic    f7_base;
    logic    f7_alt;

    assign opcode  = fetched_instr_i[6:2];
    assign funct3  = fetched_instr_i[14:12];
    assign funct7  = fetched_instr_i[31:25];
    assign size_ok = (fetched_instr_i[1:0] == INSTR_SIZE_32);
    assign f7_base = (funct7 == FUNCT7_BASE);
    assign f7_alt  = (funct7 == FUNCT7_ALT);

    always_comb begin
        instr_class_o = CLS_ILLEGAL;
        if (size_ok) begin
            case (opcode)
                OPC_OP: begin
                    // Only ADD/SUB and SRL/SRA have an alternate form.
                    if (f7_base || (f7_alt && (funct3 == F3_ADD_SUB ||
                                               funct3 == F3_SRL_SRA))) begin
                        instr_class_o = CLS_OP;
                    end
                end
                OPC_OP_IMM: begin
                    if (funct3 == F3_SLL) begin
                        if (f7_base) begin
                            instr_class_o = CLS_OP_IMM;
                        end
                    end else if (funct3 == F3_SRL_SRA) begin
                        if (f7_base || f7_alt) begin
                            instr_class_o = CLS_OP_IMM;
                        end
                    end else begin
                        instr_class_o = CLS_OP_IMM;
                    end
                end
                OPC_LOAD: begin
                    if (funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU}) begin
                        instr_class_o = CLS_LOAD;
                    end
                end
                OPC_STORE: begin
                    if (funct3 inside {F3_SB, F3_SH, F3_SW}) begin
                        instr_class_o = CLS_STORE;
                    end
                end
                OPC_BRANCH: begin
                    if (funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU}) begin
                        instr_class_o = CLS_BRANCH;
                    end
                end
                OPC_JAL: begin
                    instr_class_o = CLS_JAL;
                end
                OPC_JALR: begin
                    if (funct3 == F3_JALR) begin
                        instr_class_o = CLS_JALR;
                    end
                end
                OPC_LUI: begin
                    instr_class_o = CLS_LUI;
                end
                OPC_AUIPC: begin
                    instr_class_o = CLS_AUIPC;
                end
                OPC_MISC_MEM: begin
                    if (funct3 == F3_FENCE) begin
                        instr_class_o = CLS_FENCE;
                    end
                end
                default: begin
                    instr_class_o = CLS_ILLEGAL;
                end
            endcase
        end
    end

endmodule

/* verilog/riscv_isa_pkg.sv */
/*
 * RV32I instruction-set encodings.
 * Field types for the 32-bit instruction word, the 5-bit major opcodes
 * and the funct3 / funct7 codes used by the base integer classes.
 */
package riscv_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // Low two bits of every 32-bit instruction.
    localparam logic [1:0] INSTR_SIZE_32 = 2'b11;

    // Major opcodes, bits 6 to 2.
    localparam opcode_t OPC_LOAD     = 5'b00000;
    localparam opcode_t OPC_MISC_MEM = 5'b00011;
    localparam opcode_t OPC_OP_IMM   = 5'b00100;
    localparam opcode_t OPC_AUIPC    = 5'b00101;
    localparam opcode_t OPC_STORE    = 5'b01000;
    localparam opcode_t OPC_OP       = 5'b01100;
    localparam opcode_t OPC_LUI      = 5'b01101;
    localparam opcode_t OPC_BRANCH   = 5'b11000;
    localparam opcode_t OPC_JALR     = 5'b11001;
    localparam opcode_t OPC_JAL      = 5'b11011;

    localparam funct7_t FUNCT7_BASE = 7'h00;
    localparam funct7_t FUNCT7_ALT  = 7'h20;

    // Arithmetic and logic, shared by OP and OP_IMM.
    localparam funct3_t F3_ADD_SUB = 3'd0;
    localparam funct3_t F3_SLL     = 3'd1;
    localparam funct3_t F3_SLT     = 3'd2;
    localparam funct3_t F3_SLTU    = 3'd3;
    localparam funct3_t F3_XOR     = 3'd4;
    localparam funct3_t F3_SRL_SRA = 3'd5;
    localparam funct3_t F3_OR      = 3'd6;
    localparam funct3_t F3_AND     = 3'd7;

    // Conditional branches.
    localparam funct3_t F3_BEQ  = 3'd0;
    localparam funct3_t F3_BNE  = 3'd1;
    localparam funct3_t F3_BLT  = 3'd4;
    localparam funct3_t F3_BGE  = 3'd5;
    localparam funct3_t F3_BLTU = 3'd6;
    localparam funct3_t F3_BGEU = 3'd7;

    // Access sizes, loads and stores.
    localparam funct3_t F3_LB  = 3'd0;
    localparam funct3_t F3_LH  = 3'd1;
    localparam funct3_t F3_LW  = 3'd2;
    localparam funct3_t F3_LBU = 3'd4;
    localparam funct3_t F3_LHU = 3'd5;
    localparam funct3_t F3_SB  = 3'd0;
    localparam funct3_t F3_SH  = 3'd1;
    localparam funct3_t F3_SW  = 3'd2;

    localparam funct3_t F3_JALR  = 3'd0;
    localparam funct3_t F3_FENCE = 3'd0;

endpackage
